/* verilog/fog_cfg_pkg.sv */
package fog_cfg_pkg;

	// host register map
	localparam int CFG_ADDR_W = 2;
	localparam int CFG_DATA_W = 32;

	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_MODE   = 2'd0;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_WAIT   = 2'd1;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_OFFSET = 2'd2;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_GAIN   = 2'd3;

	// field widths of the held settings
	localparam int AVG_SEL_W    = 4;
	localparam int GAIN_SHIFT_W = 5;

	// bits left over above the mode fields
	localparam int MODE_RSVD_W = CFG_DATA_W - AVG_SEL_W - 2;

	// mode word, enable sits in bit 0
	typedef struct packed {
		logic [MODE_RSVD_W-1:0] reserved;
		logic [AVG_SEL_W-1:0]   avg_sel;
		logic                   polarity;
		logic                   enable;
	} cfg_mode_t;

	// one host word seen two ways
	// mode fields at CFG_ADDR_MODE, a plain number everywhere else
	typedef union packed {
		cfg_mode_t             mode;
		logic [CFG_DATA_W-1:0] raw;
	} cfg_word_u;

endpackage

/* verilog/fog_loop_pkg.sv */
package fog_loop_pkg;

	// detector ADC sample width
	localparam int ADC_BIT = 14;

	// accumulator and error width
	localparam int DATA_W = 32;

	// largest averaging exponent, 2^6 = 64 samples
	// 64 full-scale 14 bit samples still fit well inside DATA_W
	localparam int AVG_SEL_MAX = 6;

	// serrodyne ramp phase, wraps modulo 2^16
	localparam int PHASE_W = 16;

	// demodulator states
	// each half period waits for a trigger, settles, then averages
	typedef enum logic [2:0] {
		IDLE,
		WAIT_L,
		SETTLE_L,
		ACQ_L,
		WAIT_H,
		SETTLE_H,
		ACQ_H,
		ERR_OUT
	} demod_state_e;

endpackage

/* verilog/fog_cfg_decode.sv */
`timescale 1ns/1ps

module fog_cfg_decode (
	input  logic                                      i_clk,
	input  logic                                      i_rst_n,
	input  logic                                      i_cfg_wr,
	input  logic [fog_cfg_pkg::CFG_ADDR_W-1:0]        i_cfg_addr,
	input  fog_cfg_pkg::cfg_word_u                    i_cfg_data,
	output logic                                      o_enable,
	output logic                                      o_polarity,
	output logic [fog_cfg_pkg::AVG_SEL_W-1:0]         o_avg_sel,
	output logic [fog_cfg_pkg::CFG_DATA_W-1:0]        o_wait_cnt,
	output logic signed [fog_cfg_pkg::CFG_DATA_W-1:0] o_err_offset,
	output logic [fog_cfg_pkg::GAIN_SHIFT_W-1:0]      o_gain_shift
);

	import fog_cfg_pkg::*;
	import fog_loop_pkg::*;

	logic [AVG_SEL_W-1:0] avg_sel_clamp;

	// limit the exponent so the demodulator never sees more than 64 samples
	always_comb begin
		if (i_cfg_data.mode.avg_sel > AVG_SEL_W'(AVG_SEL_MAX)) begin
			avg_sel_clamp = AVG_SEL_W'(AVG_SEL_MAX);
		end else begin
			avg_sel_clamp = i_cfg_data.mode.avg_sel;
		end
	end

	// settings held until the next write to the same address
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_enable     <= 1'b0;
			o_polarity   <= 1'b0;
			o_avg_sel    <= '0;
			o_wait_cnt   <= '0;
			o_err_offset <= '0;
			o_gain_shift <= '0;
		end else if (i_cfg_wr) begin
			case (i_cfg_addr)
				CFG_ADDR_MODE: begin
					// mode word is decoded field by field
					o_enable   <= i_cfg_data.mode.enable;
					o_polarity <= i_cfg_data.mode.polarity;
					o_avg_sel  <= avg_sel_clamp;
				end
				CFG_ADDR_WAIT: begin
					o_wait_cnt <= i_cfg_data.raw;
				end
				CFG_ADDR_OFFSET: begin
					o_err_offset <= signed'(i_cfg_data.raw);
				end
				CFG_ADDR_GAIN: begin
					// only the low bits carry a meaningful shift
					o_gain_shift <= i_cfg_data.raw[GAIN_SHIFT_W-1:0];
				end
			endcase
		end
	end

endmodule

/* verilog/fog_err_demod.sv */
`timescale 1ns/1ps

module fog_err_demod (
	input  logic                                      i_clk,
	input  logic                                      i_rst_n,
	input  logic                                      i_enable,
	input  logic                                      i_polarity,
	input  logic [fog_cfg_pkg::AVG_SEL_W-1:0]         i_avg_sel,
	input  logic [fog_cfg_pkg::CFG_DATA_W-1:0]        i_wait_cnt,
	input  logic signed [fog_cfg_pkg::CFG_DATA_W-1:0] i_err_offset,
	input  logic                                      i_trig,
	input  logic signed [fog_loop_pkg::ADC_BIT-1:0]   i_adc_data,
	output logic signed [fog_loop_pkg::DATA_W-1:0]    o_err,
	output logic                                      o_err_valid
);

	import fog_loop_pkg::*;

	demod_state_e state;
	demod_state_e state_nxt;

	logic                     r_trig;
	logic signed [DATA_W-1:0] r_adc;
	logic [DATA_W-1:0]        r_cnt;
	logic [DATA_W-1:0]        acq_len;
	logic                     cnt_zero;
	logic signed [DATA_W-1:0] r_sum;
	logic signed [DATA_W-1:0] sum_nxt;
	logic signed [DATA_W-1:0] avg_cur;
	logic signed [DATA_W-1:0] r_avg_l;
	logic signed [DATA_W-1:0] diff;
	logic signed [DATA_W-1:0] err_nxt;

	// input register stage for trigger and ADC
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_trig <= 1'b0;
		end else begin
			r_trig <= i_trig;
		end
	end

	// sign extension to the accumulator width
	always_ff @(posedge i_clk) begin
		r_adc <= {{(DATA_W-ADC_BIT){i_adc_data[ADC_BIT-1]}}, i_adc_data};
	end

	// samples per half minus one, counted down to zero
	assign acq_len  = (DATA_W'(1) << i_avg_sel) - DATA_W'(1);
	assign cnt_zero = (r_cnt == '0);

	// running sum including this cycle's sample
	assign sum_nxt = r_sum + r_adc;
	assign avg_cur = sum_nxt >>> i_avg_sel;

	// high average plus offset minus low average
	assign diff    = avg_cur + i_err_offset - r_avg_l;
	assign err_nxt = i_polarity ? -diff : diff;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (i_enable) begin
					state_nxt = WAIT_L;
				end
			end
			WAIT_L: begin
				if (r_trig) begin
					state_nxt = SETTLE_L;
				end
			end
			SETTLE_L: begin
				if (cnt_zero) begin
					state_nxt = ACQ_L;
				end
			end
			ACQ_L: begin
				if (cnt_zero) begin
					state_nxt = WAIT_H;
				end
			end
			WAIT_H: begin
				if (r_trig) begin
					state_nxt = SETTLE_H;
				end
			end
			SETTLE_H: begin
				if (cnt_zero) begin
					state_nxt = ACQ_H;
				end
			end
			ACQ_H: begin
				if (cnt_zero) begin
					state_nxt = ERR_OUT;
				end
			end
			ERR_OUT: begin
				state_nxt = WAIT_L;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
		// disable wins from any state, period is dropped
		if (!i_enable) begin
			state_nxt = IDLE;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state   <= IDLE;
			r_cnt   <= '0;
			r_sum   <= '0;
			r_avg_l <= '0;
			o_err   <= '0;
		end else begin
			state <= state_nxt;
			case (state)
				WAIT_L, WAIT_H: begin
					// settle length is armed while waiting
					r_cnt <= i_wait_cnt;
				end
				SETTLE_L, SETTLE_H: begin
					r_sum <= '0;
					if (cnt_zero) begin
						r_cnt <= acq_len;
					end else begin
						r_cnt <= r_cnt - DATA_W'(1);
					end
				end
				ACQ_L: begin
					r_sum <= sum_nxt;
					r_cnt <= r_cnt - DATA_W'(1);
					if (cnt_zero) begin
						r_avg_l <= avg_cur;
					end
				end
				ACQ_H: begin
					r_sum <= sum_nxt;
					r_cnt <= r_cnt - DATA_W'(1);
					if (state_nxt == ERR_OUT) begin
						o_err <= err_nxt;
					end
				end
				default: begin
					r_cnt <= '0;
					r_sum <= '0;
				end
			endcase
		end
	end

	// one strobe per period, error already settled in ERR_OUT
	assign o_err_valid = (state == ERR_OUT);

endmodule

/* verilog/fog_loop_integrator.sv */
`timescale 1ns/1ps

module fog_loop_integrator (
	input  logic                                   i_clk,
	input  logic                                   i_rst_n,
	input  logic signed [fog_loop_pkg::DATA_W-1:0] i_err,
	input  logic                                   i_err_valid,
	input  logic [fog_cfg_pkg::GAIN_SHIFT_W-1:0]   i_gain_shift,
	output logic signed [fog_loop_pkg::DATA_W-1:0] o_rate,
	output logic                                   o_rate_valid,
	output logic [fog_loop_pkg::PHASE_W-1:0]       o_phase,
	output logic                                   o_ramp_valid
);

	import fog_loop_pkg::*;

	logic signed [DATA_W-1:0] err_step;
	logic [PHASE_W-1:0]       rate_lsb;

	// loop gain as an arithmetic right shift
	assign err_step = i_err >>> i_gain_shift;

	// ramp step uses the low bits of the updated rate
	assign rate_lsb = o_rate[PHASE_W-1:0];

	// first stage, rate accumulator
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rate       <= '0;
			o_rate_valid <= 1'b0;
		end else begin
			o_rate_valid <= i_err_valid;
			if (i_err_valid) begin
				o_rate <= o_rate + err_step;
			end
		end
	end

	// second stage, serrodyne phase
	// runs one cycle behind the rate so both can be busy at once
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_phase      <= '0;
			o_ramp_valid <= 1'b0;
		end else begin
			o_ramp_valid <= o_rate_valid;
			if (o_rate_valid) begin
				// wraps modulo 2^PHASE_W, a full 2 pi reset
				o_phase <= o_phase + rate_lsb;
			end
		end
	end

endmodule

/* verilog/fog_closed_loop.sv */
`timescale 1ns/1ps

module fog_closed_loop (
	input  logic                                    i_clk,
	input  logic                                    i_rst_n,
	input  logic                                    i_cfg_wr,
	input  logic [fog_cfg_pkg::CFG_ADDR_W-1:0]      i_cfg_addr,
	input  fog_cfg_pkg::cfg_word_u                  i_cfg_data,
	input  logic                                    i_trig,
	input  logic signed [fog_loop_pkg::ADC_BIT-1:0] i_adc_data,
	output logic signed [fog_loop_pkg::DATA_W-1:0]  o_err,
	output logic                                    o_err_valid,
	output logic signed [fog_loop_pkg::DATA_W-1:0]  o_rate,
	output logic                                    o_rate_valid,
	output logic [fog_loop_pkg::PHASE_W-1:0]        o_phase,
	output logic                                    o_ramp_valid
);

	import fog_cfg_pkg::*;

	// held settings from the register decode
	logic                         enable;
	logic                         polarity;
	logic [AVG_SEL_W-1:0]         avg_sel;
	logic [CFG_DATA_W-1:0]        wait_cnt;
	logic signed [CFG_DATA_W-1:0] err_offset;
	logic [GAIN_SHIFT_W-1:0]      gain_shift;

	fog_cfg_decode u_decode (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_cfg_wr     (i_cfg_wr),
		.i_cfg_addr   (i_cfg_addr),
		.i_cfg_data   (i_cfg_data),
		.o_enable     (enable),
		.o_polarity   (polarity),
		.o_avg_sel    (avg_sel),
		.o_wait_cnt   (wait_cnt),
		.o_err_offset (err_offset),
		.o_gain_shift (gain_shift)
	);

	fog_err_demod u_demod (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_enable     (enable),
		.i_polarity   (polarity),
		.i_avg_sel    (avg_sel),
		.i_wait_cnt   (wait_cnt),
		.i_err_offset (err_offset),
		.i_trig       (i_trig),
		.i_adc_data   (i_adc_data),
		.o_err        (o_err),
		.o_err_valid  (o_err_valid)
	);

	fog_loop_integrator u_integrator (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_err        (o_err),
		.i_err_valid  (o_err_valid),
		.i_gain_shift (gain_shift),
		.o_rate       (o_rate),
		.o_rate_valid (o_rate_valid),
		.o_phase      (o_phase),
		.o_ramp_valid (o_ramp_valid)
	);

endmodule

/* tests/fog_closed_loop_properties.sv */
`timescale 1ns/1ps

module fog_closed_loop_properties (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_err_valid,
	input logic i_rate_valid,
	input logic i_ramp_valid
);

	// rate stage answers each error strobe on the next cycle
	a_rate_follows_err: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) i_err_valid |=> i_rate_valid
	) else $error("o_rate_valid missing one cycle after o_err_valid");

	a_rate_needs_err: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) i_rate_valid |-> $past(i_err_valid)
	) else $error("o_rate_valid without o_err_valid one cycle before");

	// ramp stage trails the rate stage by one cycle
	a_ramp_follows_rate: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) i_rate_valid |=> i_ramp_valid
	) else $error("o_ramp_valid missing one cycle after o_rate_valid");

	a_ramp_needs_rate: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) i_ramp_valid |-> $past(i_rate_valid)
	) else $error("o_ramp_valid without o_rate_valid one cycle before");

	// all strobes quiet while reset is held
	a_quiet_in_reset: assert property (
		@(posedge i_clk) !i_rst_n |-> !(i_err_valid || i_rate_valid || i_ramp_valid)
	) else $error("strobe active while reset is held");

endmodule

bind fog_closed_loop fog_closed_loop_properties u_properties (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_err_valid  (o_err_valid),
	.i_rate_valid (o_rate_valid),
	.i_ramp_valid (o_ramp_valid)
);

/* tests/tb_fog_closed_loop.sv */
`timescale 1ns/1ps

module tb_fog_closed_loop;

	import fog_cfg_pkg::*;
	import fog_loop_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 16;
	// half period length is the settle length plus this
	localparam int HALF_EXTRA   = 80;
	localparam int MAX_WAIT     = 20;
	localparam int N_PERIODS    = 18;
	localparam int TIMEOUT_CYCLES = N_PERIODS * 2 * (MAX_WAIT + HALF_EXTRA) + 400;

	logic                        i_clk;
	logic                        i_rst_n;
	logic                        i_cfg_wr;
	logic [CFG_ADDR_W-1:0]       i_cfg_addr;
	cfg_word_u                   i_cfg_data;
	logic                        i_trig;
	logic signed [ADC_BIT-1:0]   i_adc_data;
	logic signed [DATA_W-1:0]    o_err;
	logic                        o_err_valid;
	logic signed [DATA_W-1:0]    o_rate;
	logic                        o_rate_valid;
	logic [PHASE_W-1:0]          o_phase;
	logic                        o_ramp_valid;

	// expected configuration and loop state
	int                          cur_wait;
	int                          cur_gain;
	int                          cur_avg_sel;
	logic                        cur_polarity;
	logic signed [DATA_W-1:0]    cur_offset;
	logic signed [DATA_W-1:0]    model_rate;
	logic [PHASE_W-1:0]          model_phase;
	bit                          phase_wrapped;
	int                          error_count;
	int                          cycle_cnt;

	fog_closed_loop i_dut (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_cfg_wr     (i_cfg_wr),
		.i_cfg_addr   (i_cfg_addr),
		.i_cfg_data   (i_cfg_data),
		.i_trig       (i_trig),
		.i_adc_data   (i_adc_data),
		.o_err        (o_err),
		.o_err_valid  (o_err_valid),
		.o_rate       (o_rate),
		.o_rate_valid (o_rate_valid),
		.o_phase      (o_phase),
		.o_ramp_valid (o_ramp_valid)
	);

	initial begin
		i_clk = 1'b0;
	end

	always #(CLK_PERIOD/2) i_clk = ~i_clk;

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			cycle_cnt = cycle_cnt + 1;
		end
		$display("Test failed");
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$fatal(1, "simulation timeout");
	end

	task automatic tick();
		@(posedge i_clk);
		#DRIVE_DELAY;
	endtask

	task automatic report_failure(input string msg);
		error_count = error_count + 1;
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_err(input string name, input logic signed [DATA_W-1:0] expected,
		input logic signed [DATA_W-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s err: expected %0d, actual %0d",
				name, expected, actual));
	endtask

	task automatic check_rate(input string name, input logic signed [DATA_W-1:0] expected,
		input logic signed [DATA_W-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s rate: expected %0d, actual %0d",
				name, expected, actual));
	endtask

	task automatic check_phase(input string name, input logic [PHASE_W-1:0] expected,
		input logic [PHASE_W-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch in %s phase: expected 0x%h, actual 0x%h",
				name, expected, actual));
	endtask

	task automatic check_latency(input string name, input int expected, input int actual);
		if (actual != expected)
			report_failure($sformatf("Mismatch in %s latency: expected %0d, actual %0d",
				name, expected, actual));
	endtask

	function automatic logic signed [ADC_BIT-1:0] rand_adc(input int base, input int span);
		int value;
		value = base + int'($urandom % span);
		return ADC_BIT'(value);
	endfunction

	task automatic write_cfg(input logic [CFG_ADDR_W-1:0] addr, input cfg_word_u word);
		i_cfg_wr   = 1'b1;
		i_cfg_addr = addr;
		i_cfg_data = word;
		tick();
		i_cfg_wr   = 1'b0;
	endtask

	task automatic set_value(input logic [CFG_ADDR_W-1:0] addr,
		input logic [CFG_DATA_W-1:0] value);
		cfg_word_u word;
		word.raw = value;
		write_cfg(addr, word);
		case (addr)
			CFG_ADDR_WAIT:   cur_wait = int'(value);
			CFG_ADDR_OFFSET: cur_offset = signed'(value);
			CFG_ADDR_GAIN:   cur_gain = int'(value[GAIN_SHIFT_W-1:0]);
			default: ;
		endcase
		tick();
	endtask

	task automatic set_mode(input logic enable, input logic polarity, input int avg_sel);
		cfg_word_u word;
		word.raw           = '0;
		word.mode.enable   = enable;
		word.mode.polarity = polarity;
		word.mode.avg_sel  = AVG_SEL_W'(avg_sel);
		write_cfg(CFG_ADDR_MODE, word);
		cur_polarity = polarity;
		// exponents above the limit are clamped by the decode
		cur_avg_sel  = (avg_sel > AVG_SEL_MAX) ? AVG_SEL_MAX : avg_sel;
		repeat (2) tick();
	endtask

	// one modulation period, ADC held constant over each half
	task automatic run_period(input string name, input logic signed [ADC_BIT-1:0] lo,
		input logic signed [ADC_BIT-1:0] hi, input bit expect_strobe, input int abort_at);
		int                       half_len;
		int                       n;
		bit                       seen;
		logic signed [DATA_W-1:0] exp_err;
		logic [PHASE_W-1:0]       next_phase;
		half_len = cur_wait + HALF_EXTRA;
		seen     = 1'b0;
		exp_err  = DATA_W'(hi) + cur_offset - DATA_W'(lo);
		if (cur_polarity)
			exp_err = -exp_err;
		// low half, an optional write of a disabled mode word
		i_trig     = 1'b1;
		i_adc_data = lo;
		i_cfg_addr = CFG_ADDR_MODE;
		i_cfg_data = '0;
		tick();
		i_trig = 1'b0;
		for (n = 1; n < half_len; n++) begin
			if (o_err_valid || o_rate_valid || o_ramp_valid)
				report_failure($sformatf("%s: strobe before the second trigger", name));
			i_cfg_wr = (n == abort_at);
			tick();
		end
		i_cfg_wr = 1'b0;
		if (abort_at >= 0) begin
			cur_polarity = 1'b0;
			cur_avg_sel  = 0;
		end
		// high half
		i_trig     = 1'b1;
		i_adc_data = hi;
		tick();
		i_trig = 1'b0;
		n = 1;
		while (n < half_len) begin
			if (o_rate_valid || o_ramp_valid)
				report_failure($sformatf("%s: rate or ramp strobe out of order", name));
			if (o_err_valid) begin
				if (!expect_strobe || seen)
					report_failure($sformatf("%s: unexpected err_valid", name));
				seen = 1'b1;
				check_latency(name, 3 + cur_wait + (1 << cur_avg_sel), n);
				check_err(name, exp_err, o_err);
				model_rate = model_rate + (exp_err >>> cur_gain);
				tick();
				n++;
				if (!o_rate_valid || o_err_valid || o_ramp_valid)
					report_failure($sformatf("%s: rate strobe not one cycle after err", name));
				check_rate(name, model_rate, o_rate);
				next_phase = model_phase + model_rate[PHASE_W-1:0];
				if (next_phase < model_phase)
					phase_wrapped = 1'b1;
				model_phase = next_phase;
				tick();
				n++;
				if (!o_ramp_valid || o_err_valid || o_rate_valid)
					report_failure($sformatf("%s: ramp strobe not one cycle after rate", name));
				check_phase(name, model_phase, o_phase);
			end
			tick();
			n++;
		end
		if (expect_strobe && !seen)
			report_failure($sformatf("%s: no err_valid within the period", name));
	endtask

	task automatic test_idle_after_reset();
		int p;
		check_err("reset", '0, o_err);
		check_rate("reset", '0, o_rate);
		check_phase("reset", '0, o_phase);
		for (p = 0; p < 3; p++)
			run_period("idle", rand_adc(-8192, 16384), rand_adc(-8192, 16384), 1'b0, -1);
		check_rate("idle", '0, o_rate);
		check_phase("idle", '0, o_phase);
	endtask

	task automatic test_polarity_offset();
		set_value(CFG_ADDR_WAIT, 32'd5);
		set_mode(1'b1, 1'b0, 2);
		run_period("polarity 0", -14'sd1200, 14'sd3400, 1'b1, -1);
		set_mode(1'b1, 1'b1, 2);
		run_period("polarity 1", -14'sd1200, 14'sd3400, 1'b1, -1);
		set_value(CFG_ADDR_OFFSET, -32'sd250);
		set_mode(1'b1, 1'b0, 2);
		run_period("offset", 14'sd700, -14'sd900, 1'b1, -1);
	endtask

	task automatic test_avg_sel();
		int written[4] = '{0, 3, 6, 9};
		int i;
		set_value(CFG_ADDR_WAIT, 32'd2);
		set_value(CFG_ADDR_OFFSET, 32'd100);
		for (i = 0; i < 4; i++) begin
			set_mode(1'b1, 1'b0, written[i]);
			run_period($sformatf("avg_sel %0d", written[i]), rand_adc(-8192, 16384),
				rand_adc(-8192, 16384), 1'b1, -1);
		end
	endtask

	task automatic test_rate_phase();
		int p;
		set_value(CFG_ADDR_WAIT, 32'd10);
		set_value(CFG_ADDR_OFFSET, 32'd0);
		set_value(CFG_ADDR_GAIN, 32'd2);
		set_mode(1'b1, 1'b0, 4);
		phase_wrapped = 1'b0;
		for (p = 0; p < 6; p++)
			run_period("rate", rand_adc(-8192, 2048), rand_adc(6144, 2048), 1'b1, -1);
		if (!phase_wrapped)
			report_failure("rate test: the 16 bit phase never wrapped");
	endtask

	task automatic test_disable_abort();
		set_mode(1'b1, 1'b0, 6);
		// disable lands inside the low acquisition
		run_period("abort", rand_adc(-8192, 16384), rand_adc(-8192, 16384), 1'b0,
			cur_wait + 5);
		set_mode(1'b1, 1'b0, 6);
		run_period("re-enable", rand_adc(-8192, 16384), rand_adc(-8192, 16384), 1'b1, -1);
	endtask

	initial begin : main
		void'($urandom(32'hba6a_01c7));
		i_rst_n      = 1'b1;
		i_cfg_wr     = 1'b0;
		i_cfg_addr   = '0;
		i_cfg_data   = '0;
		i_trig       = 1'b0;
		i_adc_data   = '0;
		cur_wait     = 0;
		cur_gain     = 0;
		cur_avg_sel  = 0;
		cur_polarity = 1'b0;
		cur_offset   = '0;
		model_rate   = '0;
		model_phase  = '0;
		error_count  = 0;
		#1;
		i_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge i_clk);
		#DRIVE_DELAY;
		i_rst_n = 1'b1;
		repeat (2) tick();
		test_idle_after_reset();
		test_polarity_offset();
		test_avg_sel();
		test_rate_phase();
		test_disable_abort();
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* all.f */
verilog/fog_cfg_pkg.sv
verilog/fog_loop_pkg.sv
verilog/fog_cfg_decode.sv
verilog/fog_err_demod.sv
verilog/fog_loop_integrator.sv
verilog/fog_closed_loop.sv
tests/fog_closed_loop_properties.sv
tests/tb_fog_closed_loop.sv

/* Makefile */
TOP := tb_fog_closed_loop

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
